// File: Bender.yml
package:
  name: issue_stage

sources:
  - include_dirs:
      - .
    files:
      - corePkg.sv
      - regFile.sv
      - hazardScoreboard.sv
      - issueStage.sv
      - target: simulation
        files:
          - issueStageTb.sv

// File: corePkg.sv
`include "core_params.svh"

package corePkg;

	// Data words, addresses and the pc
	typedef logic [`XLEN-1:0] wordT;

	// Register file index
	typedef logic [`REG_ADDR_W-1:0] regAddrT;

	// Instruction fields handed over by decode
	typedef logic [6:0] opcodeT;
	typedef logic [3:0] aluFnT;
	typedef logic [2:0] fnT;

	// Memory operation code, zero when the instruction has none
	typedef logic [3:0] memOpT;

	// Multiply and divide unit operation
	typedef logic [2:0] mulDivOpT;

	// Next-pc source select for fetch
	typedef logic [1:0] pcSelT;

	// Two-bit saturating counters toward decode
	typedef logic [1:0] killCountT;

	// Source of operand B in execute
	typedef enum logic [1:0] {
		BSEL_REG   = 2'd0,
		BSEL_IMM   = 2'd1,
		BSEL_SHAMT = 2'd2
	} bSelE;

	// Kill sequencer states
	// First squash cycle is the bjTaken cycle itself
	typedef enum logic {
		KILL_IDLE   = 1'b0,
		KILL_SECOND = 1'b1
	} killStateE;

endpackage

// File: core_params.svh
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// Integer datapath width
`define XLEN 32

// Architectural register count
`define NUM_REGS 32

// Index width for NUM_REGS entries
`define REG_ADDR_W 5

// Major opcode shared by LB, LH, LW, LBU and LHU
`define OPCODE_LOAD 7'b0000011

// Younger instructions squashed behind a taken branch or jump
// These are the ones sitting in decode and issue when execute resolves
`define KILL_DEPTH 2

`endif

// File: hazardScoreboard.sv
`timescale 1ns/1ns
`include "core_params.svh"

module hazardScoreboard (
	input logic clk,
	input logic nrst,
	input logic bjTaken,
	input corePkg::regAddrT rs1,
	input corePkg::regAddrT rs2,
	input corePkg::regAddrT rd4,
	input corePkg::opcodeT opcode3,
	input corePkg::memOpT memOp4,
	output logic stall,
	output logic kill,
	output corePkg::killCountT killNum
);

	import corePkg::*;

	// Major opcodes that matter for the source-use test
	localparam opcodeT OPC_LUI    = 7'b0110111;
	localparam opcodeT OPC_AUIPC  = 7'b0010111;
	localparam opcodeT OPC_JAL    = 7'b1101111;
	localparam opcodeT OPC_BRANCH = 7'b1100011;
	localparam opcodeT OPC_STORE  = 7'b0100011;
	localparam opcodeT OPC_RTYPE  = 7'b0110011;

	// Kill sequencer state
	killStateE killState;
	killStateE killStateNext;

	// Source use of the decode instruction
	logic rs1Used;
	logic rs2Used;

	// Load-use detection terms
	logic loadInExec;
	logic rs1Hit;
	logic rs2Hit;
	logic loadUse;

	// Which sources the decode instruction actually reads
	always_comb
	begin
		rs1Used = 1'b1;
		rs2Used = 1'b0;
		case (opcode3)
			// No register source
			OPC_LUI, OPC_AUIPC, OPC_JAL:
			begin
				rs1Used = 1'b0;
			end
			// Two register sources
			OPC_BRANCH, OPC_STORE, OPC_RTYPE:
			begin
				rs2Used = 1'b1;
			end
			// Loads, I-type ALU and JALR read rs1 only
			default:
			begin
				rs2Used = 1'b0;
			end
		endcase
	end

	// Memory op in execute with a destination is a load
	// Stores come out of decode with rd zero
	// Bubbles clear both fields
	assign loadInExec = (memOp4 != '0) && (rd4 != '0);

	assign rs1Hit = rs1Used && (rs1 == rd4);
	assign rs2Hit = rs2Used && (rs2 == rd4);
	assign loadUse = loadInExec && (rs1Hit || rs2Hit);

	// A squashed instruction needs no stall
	assign stall = loadUse && !kill;

	// Kill covers the bjTaken cycle and the one after
	assign kill = bjTaken || (killState == KILL_SECOND);

	// Next state of the kill sequencer
	always_comb
	begin
		killStateNext = killState;
		unique case (killState)
			KILL_IDLE:
			begin
				if (bjTaken)
				begin
					killStateNext = KILL_SECOND;
				end
			end
			KILL_SECOND:
			begin
				// Back-to-back taken restarts the window
				killStateNext = bjTaken ? KILL_SECOND : KILL_IDLE;
			end
			default:
			begin
				killStateNext = KILL_IDLE;
			end
		endcase
	end

	// State and killNum registers
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			killState <= KILL_IDLE;
			killNum <= '0;
		end
		else
		begin
			killState <= killStateNext;
			// Counts squashed slots up to the kill depth
			if (!kill)
			begin
				killNum <= '0;
			end
			else if (killNum != killCountT'(`KILL_DEPTH))
			begin
				killNum <= killNum + 1'b1;
			end
		end
	end

	// Taken branch keeps kill up in the following cycle
	killSpansNextCycle: assert property (
		@(posedge clk) disable iff (!nrst)
		bjTaken |=> kill
	);

	// Second squash cycle already has a slot counted
	killNumTracksState: assert property (
		@(posedge clk) disable iff (!nrst)
		(killState == KILL_SECOND) |-> (killNum != '0)
	);

endmodule

// File: issueStage.sv
`timescale 1ns/1ns

module issueStage (
	input logic clk,
	input logic nrst,

	// Write-back port
	input logic we6,
	input corePkg::regAddrT rdAddr6,
	input corePkg::wordT wb6,

	// Decode fields
	input corePkg::regAddrT rs1,
	input corePkg::regAddrT rs2,
	input corePkg::regAddrT rd3,
	input corePkg::opcodeT opcode3,
	input corePkg::aluFnT aluFn3,
	input corePkg::fnT fn3,
	input corePkg::bSelE bSel3,
	input corePkg::wordT iImm3,
	input corePkg::wordT bImm3,
	input corePkg::wordT jImm3,
	input corePkg::wordT sImm3,
	input corePkg::wordT uImm3,
	input logic [4:0] shamt,
	input logic we3,
	input logic bneq3,
	input logic btype3,
	input logic j3,
	input logic jr3,
	input logic lui3,
	input logic auipc3,
	input corePkg::memOpT memOp3,
	input corePkg::mulDivOpT mulDivOp3,
	input corePkg::wordT pc3,
	input corePkg::pcSelT pcSelect3,

	// Execute and memory arbiter status
	input logic bjTaken,
	input logic stallMem,
	input logic arbEqMem,
	input logic memOpDone,

	// Execute fields
	output corePkg::wordT opA,
	output corePkg::wordT opB,
	output corePkg::regAddrT rd4,
	output corePkg::aluFnT aluFn4,
	output corePkg::fnT fn4,
	output corePkg::wordT bImm4,
	output corePkg::wordT jImm4,
	output corePkg::wordT sImm4,
	output corePkg::wordT uImm4,
	output logic we4,
	output logic bneq4,
	output logic btype4,
	output logic j4,
	output logic jr4,
	output logic lui4,
	output logic auipc4,
	output corePkg::memOpT memOp4,
	output corePkg::mulDivOpT mulDivOp4,
	output corePkg::wordT pc4,
	output corePkg::pcSelT pcSelect4,

	// Back to decode
	output logic stall,
	output corePkg::killCountT killNum,
	output corePkg::killCountT stallNum
);

	import corePkg::*;

	// Combinational register file reads
	wordT rdDataA;
	wordT rdDataB;

	// Squash request from the scoreboard
	logic kill;

	// Memory back-pressure freezes stage 4
	logic hold;

	// Operand B sources held for the mux
	bSelE bSel4;
	wordT opBReg;
	wordT iImm4;
	logic [4:0] shamt4;

	assign hold = stallMem || (arbEqMem && !memOpDone);

	regFile regFileInst (
		.clk(clk),
		.nrst(nrst),
		.we(we6),
		.wrAddr(rdAddr6),
		.rdAddrA(rs1),
		.rdAddrB(rs2),
		.wrData(wb6),
		.rdDataA(rdDataA),
		.rdDataB(rdDataB)
	);

	// Load-use check runs against the registered stage-4 destination
	hazardScoreboard scoreboardInst (
		.clk(clk),
		.nrst(nrst),
		.bjTaken(bjTaken),
		.rs1(rs1),
		.rs2(rs2),
		.rd4(rd4),
		.opcode3(opcode3),
		.memOp4(memOp4),
		.stall(stall),
		.kill(kill),
		.killNum(killNum)
	);

	// Stage-4 pipeline register
	// Priority is kill, then hold, then stall, then normal issue
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			opA <= '0;
			opBReg <= '0;
			bSel4 <= BSEL_REG;
			iImm4 <= '0;
			shamt4 <= '0;
			rd4 <= '0;
			aluFn4 <= '0;
			fn4 <= '0;
			bImm4 <= '0;
			jImm4 <= '0;
			sImm4 <= '0;
			uImm4 <= '0;
			we4 <= 1'b0;
			bneq4 <= 1'b0;
			btype4 <= 1'b0;
			j4 <= 1'b0;
			jr4 <= 1'b0;
			lui4 <= 1'b0;
			auipc4 <= 1'b0;
			memOp4 <= '0;
			mulDivOp4 <= '0;
			pc4 <= '0;
			pcSelect4 <= '0;
		end
		// Hold keeps every field unless a kill overrides it
		else if (kill || !hold)
		begin
			// Pass-through immediates follow decode even into a bubble
			bImm4 <= bImm3;
			jImm4 <= jImm3;
			sImm4 <= sImm3;
			uImm4 <= uImm3;
			shamt4 <= shamt;
			if (kill || stall)
			begin
				// Bubble with no side effects
				opA <= '0;
				opBReg <= '0;
				// Zero I immediate makes opB zero
				bSel4 <= BSEL_IMM;
				iImm4 <= '0;
				rd4 <= '0;
				aluFn4 <= '0;
				fn4 <= '0;
				we4 <= 1'b0;
				bneq4 <= 1'b0;
				btype4 <= 1'b0;
				j4 <= 1'b0;
				jr4 <= 1'b0;
				lui4 <= 1'b0;
				auipc4 <= 1'b0;
				memOp4 <= '0;
				mulDivOp4 <= '0;
				pc4 <= '0;
				pcSelect4 <= '0;
			end
			else
			begin
				// Operands captured with their instruction
				opA <= rdDataA;
				opBReg <= rdDataB;
				bSel4 <= bSel3;
				iImm4 <= iImm3;
				rd4 <= rd3;
				aluFn4 <= aluFn3;
				fn4 <= fn3;
				we4 <= we3;
				bneq4 <= bneq3;
				btype4 <= btype3;
				j4 <= j3;
				jr4 <= jr3;
				lui4 <= lui3;
				auipc4 <= auipc3;
				memOp4 <= memOp3;
				mulDivOp4 <= mulDivOp3;
				pc4 <= pc3;
				pcSelect4 <= pcSelect3;
			end
		end
	end

	// Load-use stall counter, saturating at 3
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			stallNum <= '0;
		end
		else if (!stall)
		begin
			stallNum <= '0;
		end
		else if (stallNum != '1)
		begin
			stallNum <= stallNum + 1'b1;
		end
	end

	// Operand B select on registered values only
	always_comb
	begin
		unique case (bSel4)
			BSEL_REG:   opB = opBReg;
			BSEL_IMM:   opB = iImm4;
			// Shift amount is zero-extended
			BSEL_SHAMT: opB = wordT'(shamt4);
			default:    opB = opBReg;
		endcase
	end

	// Killed slot never writes back
	killBlocksWrite: assert property (
		@(posedge clk) disable iff (!nrst)
		kill |=> !we4
	);

	// Back-pressure freezes everything execute sees
	holdFreezesOutputs: assert property (
		@(posedge clk) disable iff (!nrst)
		(hold && !kill) |=> $stable({opA, opB, rd4, aluFn4, fn4, bImm4, jImm4,
			sImm4, uImm4, we4, bneq4, btype4, j4, jr4, lui4, auipc4, memOp4,
			mulDivOp4, pc4, pcSelect4})
	);

endmodule

// File: issueStageTb.sv
`timescale 1ns/1ns
`include "core_params.svh"

module issueStageTb;

	import corePkg::*;

	localparam int HALF_PERIOD = 10;
	localparam int DRIVE_DELAY = 2;
	localparam logic [31:0] SEED = 32'hdb31_b000;

	// Opcodes used to build stimulus
	localparam opcodeT OPC_LUI    = 7'b0110111;
	localparam opcodeT OPC_AUIPC  = 7'b0010111;
	localparam opcodeT OPC_JAL    = 7'b1101111;
	localparam opcodeT OPC_BRANCH = 7'b1100011;
	localparam opcodeT OPC_STORE  = 7'b0100011;
	localparam opcodeT OPC_RTYPE  = 7'b0110011;
	localparam opcodeT OPC_ITYPE  = 7'b0010011;

	logic clk;
	logic nrst;

	// DUT inputs
	logic we6;
	regAddrT rdAddr6;
	wordT wb6;
	regAddrT rs1, rs2, rd3;
	opcodeT opcode3;
	aluFnT aluFn3;
	fnT fn3;
	bSelE bSel3;
	wordT iImm3, bImm3, jImm3, sImm3, uImm3;
	logic [4:0] shamt;
	logic we3, bneq3, btype3, j3, jr3, lui3, auipc3;
	memOpT memOp3;
	mulDivOpT mulDivOp3;
	wordT pc3;
	pcSelT pcSelect3;
	logic bjTaken, stallMem, arbEqMem, memOpDone;

	// DUT outputs
	wordT opA, opB, bImm4, jImm4, sImm4, uImm4, pc4;
	regAddrT rd4;
	aluFnT aluFn4;
	fnT fn4;
	logic we4, bneq4, btype4, j4, jr4, lui4, auipc4;
	memOpT memOp4;
	mulDivOpT mulDivOp4;
	pcSelT pcSelect4;
	logic stall;
	killCountT killNum, stallNum;

	// Reference model state
	wordT refRegs [`NUM_REGS];
	logic [251:0] expOut;
	// Destination of a load sitting in stage 4
	regAddrT loadRd4;
	logic killSecond;
	killCountT expKillNum, expStallNum;
	logic lastStall;

	// All stage-4 fields side by side
	logic [251:0] actOut;
	logic memHold;

	assign actOut = {opA, opB, rd4, aluFn4, fn4, bImm4, jImm4, sImm4, uImm4, we4, bneq4,
		btype4, j4, jr4, lui4, auipc4, memOp4, mulDivOp4, pc4, pcSelect4};
	// Arbiter back-pressure as seen by stage 4
	assign memHold = stallMem || (arbEqMem && !memOpDone);

	issueStage issueStage_inst (.*);

	always #HALF_PERIOD clk = ~clk;

	task automatic failRun();
		$display("TB FAILED");
		$fatal(1);
	endtask

	task automatic reportMismatch(input string testName, input logic [255:0] expected,
		input logic [255:0] actual);
		$display("[ERROR] %s expected %0h actual %0h", testName, expected, actual);
		failRun();
	endtask

	task automatic reportProblem(input string what);
		$display("%s", what);
		failRun();
	endtask

	// Taken branch squashes the next two slots
	killGivesTwoBubbles: assert property (
		@(posedge clk) disable iff (!nrst)
		bjTaken |=> !we4 ##1 !we4
	) else reportProblem("we4 was high in a slot squashed by a taken branch");

	// Load-use bubble unless the memory hold freezes stage 4
	stallGivesBubble: assert property (
		@(posedge clk) disable iff (!nrst)
		(stall && !memHold) |=> (!we4 && rd4 == '0)
	) else reportProblem("a load-use stall did not insert a bubble");

	// Source use per major opcode
	function automatic logic usesRs1(input opcodeT opc);
		return !(opc == OPC_LUI || opc == OPC_AUIPC || opc == OPC_JAL);
	endfunction

	function automatic logic usesRs2(input opcodeT opc);
		return opc == OPC_BRANCH || opc == OPC_STORE || opc == OPC_RTYPE;
	endfunction

	// Register read seen by decode
	// Write-back is bypassed in its own cycle
	function automatic wordT readRef(input regAddrT addr);
		if (addr == '0)
			return '0;
		if (we6 && rdAddr6 == addr)
			return wb6;
		return refRegs[addr];
	endfunction

	// Never a load, so no hazard comes from here
	function automatic opcodeT randomOpcode();
		case ($urandom_range(6, 0))
			0: return OPC_LUI;
			1: return OPC_AUIPC;
			2: return OPC_JAL;
			3: return OPC_BRANCH;
			4: return OPC_STORE;
			5: return OPC_RTYPE;
			default: return OPC_ITYPE;
		endcase
	endfunction

	task automatic clearInputs();
		{we6, rdAddr6, wb6, rs1, rs2, rd3, opcode3, aluFn3, fn3} = '0;
		bSel3 = BSEL_REG;
		{iImm3, bImm3, jImm3, sImm3, uImm3, shamt} = '0;
		{we3, bneq3, btype3, j3, jr3, lui3, auipc3} = '0;
		{memOp3, mulDivOp3, pc3, pcSelect3} = '0;
		{bjTaken, stallMem, arbEqMem, memOpDone} = '0;
	endtask

	// Random decode instruction with memOp only on loads
	task automatic driveDecode(input opcodeT opc);
		opcode3 = opc;
		rs1 = regAddrT'($urandom);
		rs2 = regAddrT'($urandom);
		rd3 = regAddrT'($urandom);
		aluFn3 = aluFnT'($urandom);
		fn3 = fnT'($urandom);
		bSel3 = bSelE'($urandom_range(2, 0));
		iImm3 = $urandom;
		bImm3 = $urandom;
		jImm3 = $urandom;
		sImm3 = $urandom;
		uImm3 = $urandom;
		shamt = 5'($urandom);
		{we3, bneq3, btype3, j3, jr3, lui3, auipc3} = 7'($urandom);
		memOp3 = (opc == `OPCODE_LOAD) ? memOpT'($urandom_range(15, 1)) : '0;
		mulDivOp3 = mulDivOpT'($urandom);
		pc3 = $urandom;
		pcSelect3 = pcSelT'($urandom);
	endtask

	task automatic doReset();
		nrst = 1'b0;
		repeat (3) @(posedge clk);
		#(DRIVE_DELAY);
		nrst = 1'b1;
		foreach (refRegs[i])
			refRegs[i] = '0;
		{expOut, loadRd4, killSecond, expKillNum, expStallNum, lastStall} = '0;
	endtask

	// One cycle from a drive point to the next with inputs already set
	task automatic runCycle(input string testName);
		logic expKill;
		logic expStall;
		logic [251:0] nextOut;
		wordT bVal;
		expKill = bjTaken || killSecond;
		expStall = (loadRd4 != '0) && !expKill &&
			((usesRs1(opcode3) && rs1 == loadRd4) || (usesRs2(opcode3) && rs2 == loadRd4));
		// Operand B source picked by decode
		case (bSel3)
			BSEL_REG: bVal = readRef(rs2);
			BSEL_IMM: bVal = iImm3;
			default:  bVal = {27'd0, shamt};
		endcase
		// Bubbles still carry the pass-through immediates
		if (expKill || expStall)
			nextOut = {76'd0, bImm3, jImm3, sImm3, uImm3, 48'd0};
		else
			nextOut = {readRef(rs1), bVal, rd3, aluFn3, fn3, bImm3, jImm3, sImm3, uImm3,
				we3, bneq3, btype3, j3, jr3, lui3, auipc3, memOp3, mulDivOp3, pc3, pcSelect3};
		// Stall is combinational, checked mid-cycle
		@(negedge clk);
		lastStall = stall;
		assert (stall === expStall) else reportMismatch({testName, " stall"}, expStall, stall);
		@(posedge clk);
		// Kill overrides the memory hold
		if (expKill || !memHold)
		begin
			expOut = nextOut;
			loadRd4 = (!expKill && !expStall && opcode3 == `OPCODE_LOAD) ? rd3 : '0;
		end
		killSecond = bjTaken;
		if (!expKill)
			expKillNum = '0;
		else if (expKillNum != killCountT'(`KILL_DEPTH))
			expKillNum++;
		if (!expStall)
			expStallNum = '0;
		else if (expStallNum != 2'd3)
			expStallNum++;
		// Write lands in the array at this edge
		if (we6 && rdAddr6 != '0)
			refRegs[rdAddr6] = wb6;
		#1;
		assert (actOut === expOut) else reportMismatch({testName, " stage 4"}, expOut, actOut);
		assert (killNum === expKillNum)
			else reportMismatch({testName, " killNum"}, expKillNum, killNum);
		assert (stallNum === expStallNum)
			else reportMismatch({testName, " stallNum"}, expStallNum, stallNum);
		#(DRIVE_DELAY - 1);
	endtask

	// Load followed by a consumer that must eventually issue
	task automatic loadThenUse(input string testName, input regAddrT loadRd,
		input opcodeT useOpc, input regAddrT src1, input regAddrT src2, input logic expStall);
		int waited;
		driveDecode(`OPCODE_LOAD);
		rd3 = loadRd;
		runCycle({testName, " load"});
		driveDecode(useOpc);
		rs1 = src1;
		rs2 = src2;
		runCycle(testName);
		assert (lastStall === expStall) else reportMismatch(testName, expStall, lastStall);
		if (expStall)
		begin
			assert ({we4, rd4} === '0) else reportMismatch({testName, " bubble"}, 0, {we4, rd4});
			assert (stallNum === 2'd1) else reportMismatch({testName, " count"}, 1, stallNum);
		end
		// Decode holds the dependent instruction
		waited = 0;
		while (lastStall)
		begin
			runCycle({testName, " reissue"});
			waited++;
			if (waited > 4)
				reportProblem("dependent instruction never issued after a load-use stall");
		end
	endtask

	initial
	begin
		int waited;
		int holdCycles;
		logic [251:0] frozen;
		clk = 1'b0;
		clearInputs();
		void'($urandom(SEED));
		doReset();
		assert (actOut === '0) else reportMismatch("reset outputs", 0, actOut);
		assert ({killNum, stallNum, stall} === '0)
			else reportMismatch("reset counters", 0, {killNum, stallNum, stall});
		runCycle("reset idle");

		// Writes with x0 targets and same-cycle reads
		for (int i = 0; i < 40; i++)
		begin
			driveDecode(OPC_RTYPE);
			bSel3 = BSEL_REG;
			we6 = 1'b1;
			rdAddr6 = (i % 5 == 0) ? '0 : regAddrT'($urandom);
			wb6 = $urandom;
			rs1 = (i % 3 == 0) ? rdAddr6 : regAddrT'($urandom);
			rs2 = (i % 4 == 1) ? rdAddr6 : regAddrT'($urandom);
			runCycle("register write");
		end
		// Every register through both ports
		we6 = 1'b0;
		for (int r = 0; r < `NUM_REGS; r++)
		begin
			driveDecode(OPC_RTYPE);
			bSel3 = BSEL_REG;
			rs1 = regAddrT'(r);
			rs2 = regAddrT'(`NUM_REGS - 1 - r);
			runCycle("register readback");
		end

		// Non-hazard traffic with all operand B sources
		for (int i = 0; i < 40; i++)
		begin
			driveDecode(randomOpcode());
			runCycle("pass-through");
		end

		loadThenUse("load-use rs1", 5'd9, OPC_RTYPE, 5'd9, 5'd3, 1'b1);
		loadThenUse("load-use store rs2", 5'd14, OPC_STORE, 5'd2, 5'd14, 1'b1);
		loadThenUse("load to x0", 5'd0, OPC_RTYPE, 5'd0, 5'd0, 1'b0);
		loadThenUse("lui ignores rs1", 5'd12, OPC_LUI, 5'd12, 5'd12, 1'b0);
		loadThenUse("itype ignores rs2", 5'd12, OPC_ITYPE, 5'd3, 5'd12, 1'b0);

		// Taken branch pulse
		driveDecode(randomOpcode());
		bjTaken = 1'b1;
		runCycle("kill first");
		assert (killNum === 2'd1) else reportMismatch("kill first", 1, killNum);
		bjTaken = 1'b0;
		driveDecode(randomOpcode());
		runCycle("kill second");
		assert (killNum === 2'd2) else reportMismatch("kill second", 2, killNum);
		waited = 0;
		while (killNum !== '0)
		begin
			driveDecode(randomOpcode());
			runCycle("kill release");
			waited++;
			if (waited > 4)
				reportProblem("killNum did not return to zero after the kill window");
		end

		// Memory hold by stallMem and then by arbEqMem without done
		for (int mode = 0; mode < 2; mode++)
		begin
			driveDecode(randomOpcode());
			runCycle("before hold");
			// Predicted outputs of the last issued instruction
			frozen = expOut;
			holdCycles = $urandom_range(6, 2);
			stallMem = (mode == 0);
			arbEqMem = (mode == 1);
			memOpDone = 1'b0;
			for (int c = 0; c < holdCycles; c++)
			begin
				driveDecode(randomOpcode());
				runCycle("memory hold");
				assert (actOut === frozen) else reportMismatch("memory hold", frozen, actOut);
			end
			// Done releases the arbiter match
			stallMem = 1'b0;
			memOpDone = 1'b1;
			driveDecode(randomOpcode());
			runCycle("hold release");
			arbEqMem = 1'b0;
			memOpDone = 1'b0;
		end

		$display("TB PASSED");
		$finish;
	end

endmodule

// File: regFile.sv
`timescale 1ns/1ns
`include "core_params.svh"

module regFile (
	input logic clk,
	input logic nrst,
	input logic we,
	input corePkg::regAddrT wrAddr,
	input corePkg::regAddrT rdAddrA,
	input corePkg::regAddrT rdAddrB,
	input corePkg::wordT wrData,
	output corePkg::wordT rdDataA,
	output corePkg::wordT rdDataB
);

	import corePkg::*;

	// Register array, entry 0 stays zero
	wordT regs [`NUM_REGS];

	// Write actually lands in the array
	logic wrValid;

	// Writes to x0 are dropped here
	assign wrValid = we && (wrAddr != '0);

	// Array update on the write-back strobe
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			for (int i = 0; i < `NUM_REGS; i++)
			begin
				regs[i] <= '0;
			end
		end
		else if (wrValid)
		begin
			regs[wrAddr] <= wrData;
		end
	end

	// Port A
	// Write-back data forwarded in the cycle before it lands
	assign rdDataA = (wrValid && (rdAddrA == wrAddr)) ? wrData : regs[rdAddrA];

	// Port B
	// Same bypass rule as port A
	assign rdDataB = (wrValid && (rdAddrB == wrAddr)) ? wrData : regs[rdAddrB];

	// x0 reads zero on both ports
	// Covers the reset value, dropped writes and the bypass path together
	x0ReadsZero: assert property (
		@(posedge clk) disable iff (!nrst)
		((rdAddrA == '0) -> (rdDataA == '0)) &&
		((rdAddrB == '0) -> (rdDataB == '0))
	);

endmodule

// File: sim.f
+incdir+.
corePkg.sv
regFile.sv
hazardScoreboard.sv
issueStage.sv
issueStageTb.sv
